//--- Makefile
OBJ_DIR := obj_dir

sim:
	verilator --binary --timing --assert --top-module csr_sys_tb -f csr_sys_top.f -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vcsr_sys_tb

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean

//--- csr_sys_top.f
hw/csr_pkg.sv
hw/sys_pkg.sv
hw/csr_regfile.sv
hw/trap_ctrl.sv
hw/csr_exec_unit.sv
hw/csr_sys_top.sv
testbench/csr_sys_checker.sv
testbench/csr_sys_tb.sv

//--- hw/csr_exec_unit.sv
// Request handshake, CSR read-modify-write, legality check and the registered response.
`default_nettype none

module csr_exec_unit
  import csr_pkg::*;
  import sys_pkg::*;
(
  input  wire       i_clk,
  input  wire       i_rst,
  input  wire       i_req_valid,
  output logic      o_req_ready,
  input  sys_req_t  i_req,
  output logic      o_rsp_valid,
  input  wire       i_rsp_ready,
  output sys_rsp_t  o_rsp,
  output csr_addr_t o_raddr,
  input  xlen_t     i_rdata,
  input  wire       i_hit,
  output logic      o_wen,
  output csr_addr_t o_waddr,
  output xlen_t     o_wdata,
  output logic      o_ecall,
  output logic      o_mret,
  output xlen_t     o_pc,
  input  xlen_t     i_target
);

  logic     accept;
  logic     is_csr;
  logic     is_sys;
  logic     wants_write;
  logic     illegal;
  xlen_t    new_val;
  logic     rsp_valid_q;
  sys_rsp_t rsp_q;
  sys_rsp_t rsp_d;

  // the output register frees up in the same cycle it is unloaded.
  assign o_req_ready = ~rsp_valid_q | i_rsp_ready;
  assign accept      = i_req_valid & o_req_ready;

  always_comb begin
    is_csr  = 1'b1;
    is_sys  = 1'b0;
    new_val = i_rdata;
    case (i_req.op)
      OP_CSRRW: new_val = i_req.operand;
      OP_CSRRS: new_val = i_rdata | i_req.operand;
      OP_CSRRC: new_val = i_rdata & ~i_req.operand;
      OP_ECALL, OP_MRET: begin
        is_csr = 1'b0;
        is_sys = 1'b1;
      end
      default: begin
        is_csr = 1'b0;
      end
    endcase
  end

  // set and clear with a zero mask only read.
  assign wants_write = (i_req.op == OP_CSRRW) | (i_req.operand != '0);

  // unknown ops are rejected the same way as a bad CSR access.
  assign illegal = is_csr ? (~i_hit | (wants_write & (i_req.addr == CSR_MHARTID))) : ~is_sys;

  assign o_raddr = i_req.addr;
  assign o_wen   = accept & is_csr & wants_write & ~illegal;
  assign o_waddr = i_req.addr;
  assign o_wdata = new_val;
  assign o_ecall = accept & (i_req.op == OP_ECALL);
  assign o_mret  = accept & (i_req.op == OP_MRET);
  assign o_pc    = i_req.pc;

  always_comb begin
    rsp_d.rdata    = (is_csr & ~illegal) ? i_rdata : '0;
    rsp_d.redirect = is_sys;
    rsp_d.target   = is_sys ? i_target : '0;
    rsp_d.illegal  = illegal;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (i_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      rsp_q <= rsp_d;
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp       = rsp_q;

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
// Machine-mode CSR space: data word and address types, CSR addresses, mstatus fields and masks.
`default_nettype none

package csr_pkg;

  parameter int unsigned XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [11:0]     csr_addr_t;

  // standard machine-mode addresses.
  parameter csr_addr_t CSR_MSTATUS  = 12'h300;
  parameter csr_addr_t CSR_MTVEC    = 12'h305;
  parameter csr_addr_t CSR_MSCRATCH = 12'h340;
  parameter csr_addr_t CSR_MEPC     = 12'h341;
  parameter csr_addr_t CSR_MCAUSE   = 12'h342;
  parameter csr_addr_t CSR_MHARTID  = 12'hF14;

  // mstatus interrupt enable bits.
  parameter int unsigned MSTATUS_MIE  = 3;
  parameter int unsigned MSTATUS_MPIE = 7;

  // bits outside the writable mask stay at this pattern (MPP = M, UXL/SXL = 64-bit).
  parameter xlen_t MSTATUS_RESET = 64'ha00001800;

  parameter xlen_t MSTATUS_WMASK = (xlen_t'(1) << MSTATUS_MIE) | (xlen_t'(1) << MSTATUS_MPIE);

  // no compressed instructions are assumed, but bit 0 is always zero.
  parameter xlen_t MEPC_WMASK = ~xlen_t'(1);

  parameter xlen_t CAUSE_ECALL_M = 64'd11;

endpackage

`default_nettype wire

//--- hw/csr_regfile.sv
// Machine-mode CSR storage with write-legal masking, trap updates and the read mux.
`default_nettype none

module csr_regfile
  import csr_pkg::*;
#(
  parameter xlen_t HART_ID = '0
) (
  input  wire       i_clk,
  input  wire       i_rst,
  input  csr_addr_t i_raddr,
  input  wire       i_wen,
  input  csr_addr_t i_waddr,
  input  xlen_t     i_wdata,
  input  wire       i_trap_wen,
  input  xlen_t     i_trap_mstatus,
  input  xlen_t     i_trap_mepc,
  input  xlen_t     i_trap_mcause,
  output xlen_t     o_rdata,
  output logic      o_hit,
  output xlen_t     o_mstatus,
  output xlen_t     o_mtvec,
  output xlen_t     o_mepc,
  output xlen_t     o_mcause
);

  xlen_t mstatus_q;
  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mscratch_q;
  xlen_t mstatus_wr;

  // only MIE and MPIE follow the written value.
  assign mstatus_wr = (MSTATUS_RESET & ~MSTATUS_WMASK) | (i_wdata & MSTATUS_WMASK);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus_q  <= MSTATUS_RESET;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else if (i_trap_wen) begin
      // trap entry and return win over a software write.
      mstatus_q <= i_trap_mstatus;
      mepc_q    <= i_trap_mepc & MEPC_WMASK;
      mcause_q  <= i_trap_mcause;
    end else if (i_wen) begin
      case (i_waddr)
        CSR_MSTATUS: begin
          mstatus_q <= mstatus_wr;
        end
        CSR_MTVEC: begin
          mtvec_q <= i_wdata;
        end
        CSR_MEPC: begin
          mepc_q <= i_wdata & MEPC_WMASK;
        end
        CSR_MCAUSE: begin
          mcause_q <= i_wdata;
        end
        CSR_MSCRATCH: begin
          mscratch_q <= i_wdata;
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    o_rdata = '0;
    o_hit   = 1'b1;
    case (i_raddr)
      CSR_MSTATUS: begin
        o_rdata = mstatus_q;
      end
      CSR_MTVEC: begin
        o_rdata = mtvec_q;
      end
      CSR_MEPC: begin
        o_rdata = mepc_q;
      end
      CSR_MCAUSE: begin
        o_rdata = mcause_q;
      end
      CSR_MSCRATCH: begin
        o_rdata = mscratch_q;
      end
      CSR_MHARTID: begin
        o_rdata = HART_ID;
      end
      default: begin
        o_hit = 1'b0;
      end
    endcase
  end

  assign o_mstatus = mstatus_q;
  assign o_mtvec   = mtvec_q;
  assign o_mepc    = mepc_q;
  assign o_mcause  = mcause_q;

endmodule

`default_nettype wire

//--- hw/csr_sys_top.sv
// CSR subsystem top level: execution unit, CSR register file and trap controller.
`default_nettype none

module csr_sys_top
  import csr_pkg::*;
  import sys_pkg::*;
#(
  parameter xlen_t HART_ID = '0
) (
  input  wire      i_clk,
  input  wire      i_rst,
  input  wire      i_req_valid,
  output logic     o_req_ready,
  input  sys_req_t i_req,
  output logic     o_rsp_valid,
  input  wire      i_rsp_ready,
  output sys_rsp_t o_rsp
);

  csr_addr_t raddr;
  xlen_t     rdata;
  logic      hit;
  logic      wen;
  csr_addr_t waddr;
  xlen_t     wdata;
  logic      ecall;
  logic      mret;
  xlen_t     pc;
  xlen_t     target;
  logic      trap_wen;
  xlen_t     trap_mstatus;
  xlen_t     trap_mepc;
  xlen_t     trap_mcause;
  xlen_t     mstatus;
  xlen_t     mtvec;
  xlen_t     mepc;
  xlen_t     mcause;

  csr_exec_unit u_csr_exec_unit (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (o_rsp),
    .o_raddr     (raddr),
    .i_rdata     (rdata),
    .i_hit       (hit),
    .o_wen       (wen),
    .o_waddr     (waddr),
    .o_wdata     (wdata),
    .o_ecall     (ecall),
    .o_mret      (mret),
    .o_pc        (pc),
    .i_target    (target)
  );

  csr_regfile #(
    .HART_ID (HART_ID)
  ) u_csr_regfile (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_raddr        (raddr),
    .i_wen          (wen),
    .i_waddr        (waddr),
    .i_wdata        (wdata),
    .i_trap_wen     (trap_wen),
    .i_trap_mstatus (trap_mstatus),
    .i_trap_mepc    (trap_mepc),
    .i_trap_mcause  (trap_mcause),
    .o_rdata        (rdata),
    .o_hit          (hit),
    .o_mstatus      (mstatus),
    .o_mtvec        (mtvec),
    .o_mepc         (mepc),
    .o_mcause       (mcause)
  );

  trap_ctrl u_trap_ctrl (
    .i_ecall    (ecall),
    .i_mret     (mret),
    .i_pc       (pc),
    .i_mstatus  (mstatus),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .i_mcause   (mcause),
    .o_trap_wen (trap_wen),
    .o_mstatus  (trap_mstatus),
    .o_mepc     (trap_mepc),
    .o_mcause   (trap_mcause),
    .o_target   (target)
  );

endmodule

`default_nettype wire

//--- hw/sys_pkg.sv
// System instruction request and response channel: op encoding and payload structs.
`default_nettype none

package sys_pkg;

  import csr_pkg::*;

  typedef enum logic [2:0] {
    OP_CSRRW = 3'd1,
    OP_CSRRS = 3'd2,
    OP_CSRRC = 3'd3,
    OP_ECALL = 3'd4,
    OP_MRET  = 3'd5
  } sys_op_e;

  // operand is the write value for CSRRW and the bit mask for CSRRS and CSRRC.
  typedef struct packed {
    sys_op_e   op;
    csr_addr_t addr;
    xlen_t     operand;
    xlen_t     pc;
  } sys_req_t;

  // rdata holds the old CSR value; target is valid only with redirect.
  typedef struct packed {
    xlen_t rdata;
    logic  redirect;
    xlen_t target;
    logic  illegal;
  } sys_rsp_t;

endpackage

`default_nettype wire

//--- hw/trap_ctrl.sv
// Trap entry for ECALL and trap return for MRET: new CSR values and the redirect target.
`default_nettype none

module trap_ctrl
  import csr_pkg::*;
(
  input  wire   i_ecall,
  input  wire   i_mret,
  input  xlen_t i_pc,
  input  xlen_t i_mstatus,
  input  xlen_t i_mtvec,
  input  xlen_t i_mepc,
  input  xlen_t i_mcause,
  output logic  o_trap_wen,
  output xlen_t o_mstatus,
  output xlen_t o_mepc,
  output xlen_t o_mcause,
  output xlen_t o_target
);

  always_comb begin
    o_mstatus = i_mstatus;
    o_mepc    = i_mepc;
    o_mcause  = i_mcause;
    o_target  = '0;
    if (i_ecall) begin
      // save the enable and mask interrupts on entry.
      o_mstatus[MSTATUS_MPIE] = i_mstatus[MSTATUS_MIE];
      o_mstatus[MSTATUS_MIE]  = 1'b0;
      o_mepc                  = i_pc & MEPC_WMASK;
      o_mcause                = CAUSE_ECALL_M;
      // the mode bits are ignored and every trap goes to the base.
      o_target                = {i_mtvec[XLEN-1:2], 2'b00};
    end else if (i_mret) begin
      o_mstatus[MSTATUS_MIE]  = i_mstatus[MSTATUS_MPIE];
      o_mstatus[MSTATUS_MPIE] = 1'b1;
      o_target                = i_mepc;
    end
  end

  assign o_trap_wen = i_ecall | i_mret;

endmodule

`default_nettype wire

//--- testbench/csr_sys_checker.sv
// Bound assertions on the CSR subsystem response handshake and reset behavior.
`default_nettype none

module csr_sys_checker
  import sys_pkg::*;
(
  input wire           i_clk,
  input wire           i_rst,
  input wire           i_req_ready,
  input wire           i_rsp_valid,
  input wire           i_rsp_ready,
  input wire sys_rsp_t i_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // a stalled response keeps its valid and its payload.
  a_rsp_hold: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp))
  ) else begin
    fail_count++;
    $error("response changed or dropped while stalled");
  end

  a_reset_clears_valid: assert property (
    @(posedge i_clk) i_rst |=> !i_rsp_valid
  ) else begin
    fail_count++;
    $error("response valid is set in the cycle after reset");
  end

  // an empty output register always takes a request.
  a_ready_when_empty: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !i_rsp_valid |-> i_req_ready
  ) else begin
    fail_count++;
    $error("request ready is low with no response held");
  end

endmodule

bind csr_sys_top csr_sys_checker u_csr_sys_checker (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_req_ready (o_req_ready),
  .i_rsp_valid (o_rsp_valid),
  .i_rsp_ready (i_rsp_ready),
  .i_rsp       (o_rsp)
);

`default_nettype wire

//--- testbench/csr_sys_tb.sv
// Testbench for the CSR subsystem: clock, reset, random requests, reference model and checks.
`default_nettype none

module csr_sys_tb
  import csr_pkg::*;
  import sys_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam xlen_t TB_HART_ID     = 64'h0000_0000_0000_0003;
  localparam int    NUM_REQ        = 400;
  localparam int    TIMEOUT_CYCLES = NUM_REQ * 10 + 200;

  logic     i_clk;
  logic     i_rst;
  logic     i_req_valid;
  logic     o_req_ready;
  sys_req_t i_req;
  logic     o_rsp_valid;
  logic     i_rsp_ready;
  sys_rsp_t o_rsp;

  // reference model of the architectural registers.
  xlen_t    m_mstatus;
  xlen_t    m_mtvec;
  xlen_t    m_mepc;
  xlen_t    m_mcause;
  xlen_t    m_mscratch;
  sys_rsp_t exp_q[$];

  integer   seed;
  sys_req_t cur_req;
  logic     holding;
  int       sent;
  int       accepted;
  int       gap_left;
  int       cycle_count;

  csr_sys_top #(
    .HART_ID (TB_HART_ID)
  ) u_csr_sys_top (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (o_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d of %0d requests done", cycle_count, accepted,
             NUM_REQ);
    $display("Simulation FAILED");
    $fatal(1, "run did not finish in time");
  end

  function automatic int unsigned next_rand();
    return $unsigned($random(seed));
  endfunction

  function automatic csr_addr_t addr_by_index(int unsigned idx);
    case (idx)
      0: return CSR_MSTATUS;
      1: return CSR_MTVEC;
      2: return CSR_MEPC;
      3: return CSR_MCAUSE;
      4: return CSR_MSCRATCH;
      default: return CSR_MHARTID;
    endcase
  endfunction

  // the first six requests read every CSR once with a zero set mask.
  function automatic sys_req_t build_request(int idx);
    sys_req_t    req;
    int unsigned pick;
    req.pc = {$random(seed), $random(seed)};
    if (idx < 6) begin
      req.op      = OP_CSRRS;
      req.addr    = addr_by_index(idx);
      req.operand = '0;
    end else begin
      pick = next_rand() % 16;
      if (pick < 4) req.op = OP_CSRRW;
      else if (pick < 8) req.op = OP_CSRRS;
      else if (pick < 12) req.op = OP_CSRRC;
      else if (pick < 14) req.op = OP_ECALL;
      else req.op = OP_MRET;
      pick = next_rand() % 8;
      req.addr = (pick < 6) ? addr_by_index(pick) : csr_addr_t'(next_rand());
      req.operand = (next_rand() % 4 == 0) ? '0 : {$random(seed), $random(seed)};
    end
    return req;
  endfunction

  task automatic write_model(input csr_addr_t addr, input xlen_t value);
    case (addr)
      CSR_MSTATUS: begin
        m_mstatus               = MSTATUS_RESET;
        m_mstatus[MSTATUS_MIE]  = value[MSTATUS_MIE];
        m_mstatus[MSTATUS_MPIE] = value[MSTATUS_MPIE];
      end
      CSR_MTVEC: m_mtvec = value;
      CSR_MEPC: m_mepc = value & ~xlen_t'(1);
      CSR_MCAUSE: m_mcause = value;
      CSR_MSCRATCH: m_mscratch = value;
      default: begin
      end
    endcase
  endtask

  task automatic model_accept(input sys_req_t req);
    sys_rsp_t exp;
    xlen_t    old_val;
    xlen_t    new_val;
    logic     hit;
    logic     writes;
    exp     = '0;
    hit     = 1'b1;
    old_val = '0;
    case (req.addr)
      CSR_MSTATUS: old_val = m_mstatus;
      CSR_MTVEC: old_val = m_mtvec;
      CSR_MEPC: old_val = m_mepc;
      CSR_MCAUSE: old_val = m_mcause;
      CSR_MSCRATCH: old_val = m_mscratch;
      CSR_MHARTID: old_val = TB_HART_ID;
      default: hit = 1'b0;
    endcase
    case (req.op)
      OP_ECALL: begin
        exp.redirect            = 1'b1;
        exp.target              = m_mtvec & ~xlen_t'(3);
        m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
        m_mstatus[MSTATUS_MIE]  = 1'b0;
        m_mepc                  = req.pc & ~xlen_t'(1);
        m_mcause                = 64'd11;
      end
      OP_MRET: begin
        exp.redirect            = 1'b1;
        exp.target              = m_mepc;
        m_mstatus[MSTATUS_MIE]  = m_mstatus[MSTATUS_MPIE];
        m_mstatus[MSTATUS_MPIE] = 1'b1;
      end
      default: begin
        writes = (req.op == OP_CSRRW) || (req.operand != '0);
        if (!hit || (writes && req.addr == CSR_MHARTID)) begin
          exp.illegal = 1'b1;
        end else begin
          exp.rdata = old_val;
          if (req.op == OP_CSRRW) new_val = req.operand;
          else if (req.op == OP_CSRRS) new_val = old_val | req.operand;
          else new_val = old_val & ~req.operand;
          if (writes) write_model(req.addr, new_val);
        end
      end
    endcase
    exp_q.push_back(exp);
  endtask

  task automatic check_value(input string field, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, field, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic check_response();
    sys_rsp_t exp;
    exp = exp_q.pop_front();
    check_value("rdata", o_rsp.rdata, exp.rdata);
    check_value("redirect", xlen_t'(o_rsp.redirect), xlen_t'(exp.redirect));
    check_value("target", o_rsp.target, exp.target);
    check_value("illegal", xlen_t'(o_rsp.illegal), xlen_t'(exp.illegal));
  endtask

  // called at a falling edge; a new request is offered only once the last one is taken.
  task automatic drive_inputs();
    i_rsp_ready = (next_rand() % 10) < 6;
    if (!holding && sent < NUM_REQ) begin
      if (gap_left > 0) begin
        gap_left--;
      end else begin
        cur_req = build_request(sent);
        sent++;
        holding = 1'b1;
      end
    end
    i_req_valid = holding;
    i_req       = cur_req;
  endtask

  // sample mid-cycle, after the inputs settle and before the rising edge that transfers.
  task automatic run_cycle();
    #2;
    check_value("rsp_valid", xlen_t'(o_rsp_valid), xlen_t'(exp_q.size() != 0));
    check_value("req_ready", xlen_t'(o_req_ready), xlen_t'(exp_q.size() == 0 || i_rsp_ready));
    if (o_rsp_valid && i_rsp_ready) begin
      check_response();
    end
    if (i_req_valid && o_req_ready) begin
      model_accept(i_req);
      holding  = 1'b0;
      gap_left = next_rand() % 4;
      accepted++;
    end
    @(negedge i_clk);
  endtask

  initial begin
    seed        = 32'hea342fe8;
    i_rst       = 1'b1;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_rsp_ready = 1'b0;
    cur_req     = '0;
    holding     = 1'b0;
    sent        = 0;
    accepted    = 0;
    gap_left    = 0;
    m_mstatus   = MSTATUS_RESET;
    m_mtvec     = '0;
    m_mepc      = '0;
    m_mcause    = '0;
    m_mscratch  = '0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    while (accepted < NUM_REQ || exp_q.size() != 0) begin
      drive_inputs();
      run_cycle();
    end
    // idle cycles catch a duplicated response.
    repeat (8) begin
      drive_inputs();
      run_cycle();
    end
    if (u_csr_sys_top.u_csr_sys_checker.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures in the checker",
               u_csr_sys_top.u_csr_sys_checker.fail_count);
      $display("Simulation FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire
